//--- logic/lcd_pkg.sv
package lcd_pkg;

	localparam logic [8:0] dots_per_line = 9'd456;
	localparam logic [7:0] lines_per_frame = 8'd154;
	localparam logic [7:0] visible_lines = 8'd144;
	localparam logic [8:0] oam_scan_dots = 9'd80; // First dot of pixel transfer.
	localparam logic [7:0] pixels_per_line = 8'd160;

	typedef enum logic [1:0] {
		mode_hblank   = 2'd0,
		mode_vblank   = 2'd1,
		mode_oam      = 2'd2,
		mode_transfer = 2'd3
	} lcd_mode_t;

	// Current dot within the line and current line within the frame.
	typedef struct packed {
		logic [8:0] h;
		logic [7:0] v;
	} lcd_pos_t;

	typedef struct packed {
		logic cpl;     // Line latch.
		logic fr;      // Frame alternation.
		logic st;      // Line start.
		logic s;       // Vertical sync.
		logic clkpipe; // Pixel pipe clock.
	} lcd_pins_t;

endpackage

//--- logic/lcd_position_counter.sv
`timescale 1ns/1ns

module lcd_position_counter (
	input  logic                clk2,
	input  logic                reset,
	input  logic                lcd_on,
	output lcd_pkg::lcd_pos_t   pos,
	output logic                line_end,
	output logic                frame_start
);

	logic last_line;

	assign line_end = pos.h == lcd_pkg::dots_per_line - 9'd1;
	assign last_line = pos.v == lcd_pkg::lines_per_frame - 8'd1;
	assign frame_start = (pos.h == 9'd0) && (pos.v == 8'd0); // Also high while the display is off.

	always_ff @(posedge clk2) begin
		if (reset) begin
			pos <= '0;
		end else if (!lcd_on) begin
			pos <= '0; // Counters hold at the origin while disabled.
		end else if (line_end) begin
			pos.h <= '0;
			if (last_line) begin
				pos.v <= '0;
			end else begin
				pos.v <= pos.v + 8'd1;
			end
		end else begin
			pos.h <= pos.h + 9'd1;
		end
	end

	position_in_range: assert property (
		@(posedge clk2) disable iff (reset)
		(pos.h < lcd_pkg::dots_per_line) && (pos.v < lcd_pkg::lines_per_frame)
	);

endmodule

//--- logic/lcd_timing_control.sv
`timescale 1ns/1ns

module lcd_timing_control (
	input  logic                clk2,
	input  logic                reset,
	input  logic                lcd_on,
	input  lcd_pkg::lcd_pos_t   pos,
	input  logic                line_end,
	input  logic                frame_start,
	input  logic                pixel_done,
	output lcd_pkg::lcd_mode_t  mode,
	output logic                render_en,
	output logic                line_end_q,
	output logic                frame_start_q
);

	lcd_pkg::lcd_mode_t mode_d;
	logic [7:0] v_next;
	logic       next_visible;

	// Line number of the following cycle, so that mode can be registered ahead.
	always_comb begin
		v_next = pos.v;
		if (line_end) begin
			if (pos.v == lcd_pkg::lines_per_frame - 8'd1) begin
				v_next = 8'd0;
			end else begin
				v_next = pos.v + 8'd1;
			end
		end
	end

	assign next_visible = v_next < lcd_pkg::visible_lines;

	always_comb begin
		if (!lcd_on) begin
			mode_d = lcd_pkg::mode_hblank;
		end else if (!next_visible) begin
			mode_d = lcd_pkg::mode_vblank;
		end else if (line_end || (pos.h < lcd_pkg::oam_scan_dots - 9'd1)) begin
			mode_d = lcd_pkg::mode_oam; // Next dot is inside the OAM scan window.
		end else if (pos.h == lcd_pkg::oam_scan_dots - 9'd1) begin
			mode_d = lcd_pkg::mode_transfer;
		end else if ((mode == lcd_pkg::mode_transfer) && pixel_done) begin
			mode_d = lcd_pkg::mode_hblank; // Last pixel has left the pipe.
		end else begin
			mode_d = mode;
		end
	end

	always_ff @(posedge clk2) begin
		if (reset) begin
			mode <= lcd_pkg::mode_oam;
		end else begin
			mode <= mode_d;
		end
	end

	assign render_en = mode == lcd_pkg::mode_transfer;

	// Strobes are only meaningful to the pins while the panel is driven.
	assign line_end_q = line_end && lcd_on;
	assign frame_start_q = frame_start && lcd_on;

	no_transfer_in_vblank: assert property (
		@(posedge clk2) disable iff (reset)
		(mode == lcd_pkg::mode_transfer) |-> (pos.v < lcd_pkg::visible_lines)
	);

	// A transfer must finish before the last dot of its line.
	transfer_ends_in_line: assert property (
		@(posedge clk2) disable iff (reset)
		(mode == lcd_pkg::mode_transfer) |-> !line_end
	);

endmodule

//--- logic/lcd_pixel_clock.sv
`timescale 1ns/1ns

module lcd_pixel_clock (
	input  logic clk2,
	input  logic reset,
	input  logic render_en,
	input  logic fetch_stall,
	output logic pipe_clk,
	output logic first_pixel,
	output logic pixel_done
);

	logic [7:0] pixel_count;

	// A stalled fetch holds the pipe, so no pixel is dropped.
	assign pipe_clk = render_en && !fetch_stall;

	assign first_pixel = pipe_clk && (pixel_count == 8'd0);
	assign pixel_done = pipe_clk && (pixel_count == lcd_pkg::pixels_per_line - 8'd1);

	always_ff @(posedge clk2) begin
		if (reset) begin
			pixel_count <= '0;
		end else if (!render_en) begin
			pixel_count <= '0; // Ready for the next line.
		end else if (pipe_clk) begin
			pixel_count <= pixel_count + 8'd1;
		end
	end

	count_in_range: assert property (
		@(posedge clk2) disable iff (reset)
		pixel_count <= lcd_pkg::pixels_per_line
	);

endmodule

//--- logic/lcd_pin_driver.sv
`timescale 1ns/1ns

module lcd_pin_driver (
	input  logic                clk2,
	input  logic                reset,
	input  logic                lcd_on,
	input  logic [1:0]          div_bits,
	input  lcd_pkg::lcd_pos_t   pos,
	input  logic                line_end_q,
	input  logic                frame_start_q,
	input  logic                first_pixel,
	input  logic                pipe_clk,
	output lcd_pkg::lcd_pins_t  pins
);

	logic fr_state;
	logic fr_next;

	// Frame start resynchronises the alternation; 154 lines keep it even.
	always_comb begin
		if (frame_start_q) begin
			fr_next = 1'b0;
		end else begin
			fr_next = fr_state ^ line_end_q;
		end
	end

	always_ff @(posedge clk2) begin
		if (reset || !lcd_on) begin
			fr_state <= 1'b0;
		end else begin
			fr_state <= fr_next;
		end
	end

	always_ff @(posedge clk2) begin
		if (reset) begin
			pins <= '0;
		end else if (lcd_on) begin
			pins.cpl <= line_end_q;
			pins.fr <= fr_next;
			pins.st <= first_pixel;
			pins.s <= pos.v == 8'd0;
			pins.clkpipe <= pipe_clk;
		end else begin
			pins.cpl <= div_bits[0]; // Display off lets the divider run the panel.
			pins.fr <= div_bits[1];
			pins.st <= 1'b0;
			pins.s <= 1'b0;
			pins.clkpipe <= 1'b0;
		end
	end

endmodule

//--- logic/lcd_subsystem.sv
`timescale 1ns/1ns

module lcd_subsystem (
	input  logic                clk2,
	input  logic                reset,
	input  logic                lcd_on,
	input  logic [1:0]          div_bits,
	input  logic                fetch_stall,
	output lcd_pkg::lcd_pins_t  pins,
	output lcd_pkg::lcd_pos_t   pos,
	output lcd_pkg::lcd_mode_t  mode
);

	logic line_end;
	logic frame_start;
	logic line_end_q;
	logic frame_start_q;
	logic render_en;
	logic pipe_clk;
	logic first_pixel;
	logic pixel_done;

	lcd_position_counter lcd_position_counter_inst (
		.clk2        (clk2),
		.reset       (reset),
		.lcd_on      (lcd_on),
		.pos         (pos),
		.line_end    (line_end),
		.frame_start (frame_start)
	);

	lcd_timing_control lcd_timing_control_inst (
		.clk2          (clk2),
		.reset         (reset),
		.lcd_on        (lcd_on),
		.pos           (pos),
		.line_end      (line_end),
		.frame_start   (frame_start),
		.pixel_done    (pixel_done),
		.mode          (mode),
		.render_en     (render_en),
		.line_end_q    (line_end_q),
		.frame_start_q (frame_start_q)
	);

	lcd_pixel_clock lcd_pixel_clock_inst (
		.clk2        (clk2),
		.reset       (reset),
		.render_en   (render_en),
		.fetch_stall (fetch_stall),
		.pipe_clk    (pipe_clk),
		.first_pixel (first_pixel),
		.pixel_done  (pixel_done)
	);

	lcd_pin_driver lcd_pin_driver_inst (
		.clk2          (clk2),
		.reset         (reset),
		.lcd_on        (lcd_on),
		.div_bits      (div_bits),
		.pos           (pos),
		.line_end_q    (line_end_q),
		.frame_start_q (frame_start_q),
		.first_pixel   (first_pixel),
		.pipe_clk      (pipe_clk),
		.pins          (pins)
	);

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk2,
	output logic reset
);

	initial begin
		clk2 = 1'b0;
		forever #4 clk2 = ~clk2; // 8 ns period.
	end

	initial begin
		reset <= 1'b1;
		repeat (2) @(posedge clk2);
		reset <= 1'b0; // Released after two rising edges.
	end

endmodule

//--- tb/lcd_subsystem_tb.sv
`timescale 1ns/1ns

module lcd_subsystem_tb;

	localparam int frame_cycles = int'(lcd_pkg::dots_per_line) * int'(lcd_pkg::lines_per_frame);
	localparam int on_phases = 3;
	localparam int max_extra = 1023;
	localparam int max_off = 16 + 63;
	localparam int tail_cycles = 512;
	localparam int max_stall = 150;
	localparam int run_cycles = on_phases * (frame_cycles + max_extra + max_off) + tail_cycles + 8;
	localparam int watchdog_ns = run_cycles * 8 * 2;

	logic clk2;
	logic reset;
	logic lcd_on;
	logic [1:0] div_bits;
	logic fetch_stall;
	lcd_pkg::lcd_pins_t pins;
	lcd_pkg::lcd_pos_t pos;
	lcd_pkg::lcd_mode_t mode;

	logic [31:0] rng_state = 32'd2717;
	int stall_count = 0;
	int extra;
	int off_cycles;

	// Model state, always holding what the DUT registers show in the current cycle.
	lcd_pkg::lcd_pos_t m_pos = '0;
	lcd_pkg::lcd_mode_t m_mode = lcd_pkg::mode_oam;
	lcd_pkg::lcd_pins_t m_pins = '0;
	logic [7:0] m_count = 8'd0;
	logic m_fr = 1'b0;
	int clk_pulses = 0;
	logic line_whole = 1'b0;

	tb_clock_gen clock_gen_inst (
		.clk2  (clk2),
		.reset (reset)
	);

	lcd_subsystem lcd_subsystem_inst (
		.clk2        (clk2),
		.reset       (reset),
		.lcd_on      (lcd_on),
		.div_bits    (div_bits),
		.fetch_stall (fetch_stall),
		.pins        (pins),
		.pos         (pos),
		.mode        (mode)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check_pos(input string name, input lcd_pkg::lcd_pos_t exp,
			input lcd_pkg::lcd_pos_t act);
		if (exp !== act) begin
			$display("FAILED %s expected h=%0d v=%0d actual h=%0d v=%0d",
				name, exp.h, exp.v, act.h, act.v);
			$display("SIMULATION FAILED");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic check_mode(input string name, input lcd_pkg::lcd_mode_t exp,
			input lcd_pkg::lcd_mode_t act);
		if (exp !== act) begin
			$display("FAILED %s expected %s actual %s", name, exp.name(), act.name());
			$display("SIMULATION FAILED");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic check_pins(input string name, input lcd_pkg::lcd_pins_t exp,
			input lcd_pkg::lcd_pins_t act);
		if (exp !== act) begin
			$display("FAILED %s expected cpl,fr,st,s,clkpipe=%b actual %b", name, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("FAILED %s expected %0d actual %0d", name, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	// One rising edge of the model, using the inputs that the DUT sees at that edge.
	task automatic advance_model();
		logic line_end;
		logic render;
		logic pipe;
		logic first;
		logic done;
		logic le_q;
		logic fs_q;
		logic fr_next;
		lcd_pkg::lcd_pos_t n_pos;
		line_end = m_pos.h == lcd_pkg::dots_per_line - 9'd1;
		render = m_mode == lcd_pkg::mode_transfer;
		pipe = render && !fetch_stall;
		first = pipe && (m_count == 8'd0);
		done = pipe && (m_count == lcd_pkg::pixels_per_line - 8'd1);
		le_q = line_end && lcd_on;
		fs_q = (m_pos == '0) && lcd_on;
		fr_next = fs_q ? 1'b0 : (m_fr ^ le_q);
		n_pos = '0;
		if (!reset && lcd_on) begin
			if (line_end) begin
				n_pos.v = (m_pos.v == lcd_pkg::lines_per_frame - 8'd1) ? 8'd0 : m_pos.v + 8'd1;
			end else begin
				n_pos.h = m_pos.h + 9'd1;
				n_pos.v = m_pos.v;
			end
		end
		if (reset) begin
			m_mode = lcd_pkg::mode_oam;
		end else if (!lcd_on) begin
			m_mode = lcd_pkg::mode_hblank;
		end else if (n_pos.v >= lcd_pkg::visible_lines) begin
			m_mode = lcd_pkg::mode_vblank;
		end else if (n_pos.h < lcd_pkg::oam_scan_dots) begin
			m_mode = lcd_pkg::mode_oam;
		end else if (n_pos.h == lcd_pkg::oam_scan_dots) begin
			m_mode = lcd_pkg::mode_transfer;
		end else if (done) begin
			m_mode = lcd_pkg::mode_hblank; // Blank follows the 160th pixel.
		end
		if (reset || !render) begin
			m_count = 8'd0;
		end else if (pipe) begin
			m_count = m_count + 8'd1;
		end
		m_fr = (reset || !lcd_on) ? 1'b0 : fr_next;
		if (reset) begin
			m_pins = '0;
		end else if (lcd_on) begin
			m_pins.cpl = le_q;
			m_pins.fr = fr_next;
			m_pins.st = first;
			m_pins.s = m_pos.v == 8'd0;
			m_pins.clkpipe = pipe;
		end else begin
			m_pins.cpl = div_bits[0];
			m_pins.fr = div_bits[1];
			m_pins.st = 1'b0;
			m_pins.s = 1'b0;
			m_pins.clkpipe = 1'b0;
		end
		m_pos = n_pos;
	endtask

	task automatic drive_cycle(input logic on);
		logic stall;
		@(posedge clk2);
		rng_state = lcg_next(rng_state);
		if (m_pos.h == 9'd0) begin
			stall_count = 0;
		end
		stall = (rng_state[17:16] == 2'b00) && (stall_count < max_stall);
		if (stall) begin
			stall_count = stall_count + 1;
		end
		lcd_on <= on;
		div_bits <= rng_state[24:23];
		fetch_stall <= stall;
	endtask

	always @(negedge clk2) begin
		check_pos("position", m_pos, pos);
		check_mode("mode", m_mode, mode);
		check_pins("pins", m_pins, pins);
		if (m_pos.h == 9'd0) begin
			clk_pulses = 0;
			line_whole = lcd_on;
		end
		line_whole = line_whole && lcd_on && !reset;
		if (pins.clkpipe) begin
			clk_pulses = clk_pulses + 1;
		end
		if (line_whole && (m_pos.h == lcd_pkg::dots_per_line - 9'd1)) begin
			check_count("clkpipe pulses per line",
				(m_pos.v < lcd_pkg::visible_lines) ? 160 : 0, clk_pulses);
		end
		advance_model();
	end

	initial begin
		#(watchdog_ns);
		$display("Timeout: the simulation did not finish in the expected time.");
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		lcd_on <= 1'b1;
		div_bits <= 2'b00;
		fetch_stall <= 1'b0;
		wait (!reset);
		for (int phase = 0; phase < on_phases; phase++) begin
			rng_state = lcg_next(rng_state);
			extra = int'(rng_state[25:16]); // Drop the display part way into a frame.
			repeat (frame_cycles + extra) drive_cycle(1'b1);
			rng_state = lcg_next(rng_state);
			off_cycles = 16 + int'(rng_state[21:16]);
			repeat (off_cycles) drive_cycle(1'b0);
		end
		repeat (tail_cycles) drive_cycle(1'b1);
		@(posedge clk2);
		@(negedge clk2);
		#1;
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- vlog.f
logic/lcd_pkg.sv
logic/lcd_position_counter.sv
logic/lcd_timing_control.sv
logic/lcd_pixel_clock.sv
logic/lcd_pin_driver.sv
logic/lcd_subsystem.sv
tb/tb_clock_gen.sv
tb/lcd_subsystem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the LCD subsystem testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module lcd_subsystem_tb -f vlog.f -o sim_lcd \
	&& ./obj_dir/sim_lcd | tee /dev/stderr | grep -qx "SIMULATION PASSED" \
	&& echo "run_sim: run completed" \
	|| { echo "run_sim: run did not pass"; exit 1; }
